// ==== bench/lsu_bus_sva.sv ====
//////////////////////////////////////////////////////////////////////
// data bus protocol assertions bound into the top level
// sequencer state is taken from the FSM instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_bus_sva (
  input logic                  clk_i,
  input logic                  rst_ni,
  input lsu_op_pkg::lsu_state_e state_i,
  input logic                  data_req_i,
  input logic                  data_gnt_i,
  input logic                  data_rvalid_i,
  input logic                  data_err_i,
  input logic [31:0]           data_addr_i,
  input logic                  data_we_i,
  input logic [3:0]            data_be_i,
  input logic [31:0]           data_wdata_i,
  input logic                  load_err_i,
  input logic                  store_err_i
);
  import lsu_op_pkg::*;

  int unsigned fail_cnt = 0;  // failed assertions so far

  rvalid_not_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> state_i != IDLE)
    else begin
      $error("data_rvalid_i arrived while the sequencer was idle");
      fail_cnt++;
    end

  // a bus error only comes with rvalid and always reaches the core
  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_err_i |-> (data_rvalid_i && (load_err_i || store_err_i)))
    else begin
      $error("data_err_i without rvalid or not reported as a load or store error");
      fail_cnt++;
    end

  req_addr_lanes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i |-> (data_addr_i[1:0] == 2'b00 && data_be_i != 4'b0000))
    else begin
      $error("request address not word aligned or no byte lane enabled");
      fail_cnt++;
    end

  // fields hold while the request waits for its grant
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i) &&
      $stable(data_we_i) && $stable(data_be_i) && $stable(data_wdata_i)))
    else begin
      $error("request dropped or changed before its grant");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_bus_sva lsu_bus_sva_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .state_i       (lsu_bus_fsm_inst.state_q),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_err_i    (data_err_i),
  .data_addr_i   (data_addr_o),
  .data_we_i     (data_we_o),
  .data_be_i     (data_be_o),
  .data_wdata_i  (data_wdata_o),
  .load_err_i    (load_err_o),
  .store_err_i   (store_err_o)
);

`default_nettype wire

// ==== bench/lsu_checker.sv ====
//////////////////////////////////////////////////////////////////////
// result and bus request checker sampling at the falling clock edge
// expected byte lanes come from the access size and byte offset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        we_i,
  input  logic [1:0]  size_i,
  input  logic [31:0] addr_i,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic        data_valid_i,
  input  logic [31:0] rdata_i,
  input  logic        load_err_i,
  input  logic        store_err_i,
  input  logic [1:0]  err_part_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        exp_err_i,
  output int unsigned err_cnt_o,
  output int unsigned done_cnt_o
);
  int unsigned err_cnt  = 0;
  int unsigned done_cnt = 0;
  int unsigned part_cnt = 0;  // accepted requests of the current access

  assign err_cnt_o  = err_cnt;
  assign done_cnt_o = done_cnt;

  // bytes of the access over two words with the first word in the lower nibble
  function automatic logic [7:0] access_lanes(input logic [1:0] size,
                                              input logic [1:0] offs);
    logic [7:0] ones;
    case (size)
      2'd0:    ones = 8'h0f;
      2'd1:    ones = 8'h03;
      default: ones = 8'h01;
    endcase
    return ones << offs;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    $display("FAILED t=%0t %s expected %08h got %08h", $time, name, exp_val, got_val);
    err_cnt++;
  endtask

  always @(negedge clk_i) begin : compare
    logic [7:0]  lanes;
    logic [3:0]  exp_be;
    logic [31:0] exp_addr;
    int unsigned exp_reqs;
    if (rst_ni) begin
      lanes = access_lanes(size_i, addr_i[1:0]);
      if (data_req_i && data_gnt_i) begin  // accepted at the next rising edge
        exp_be   = (part_cnt == 0) ? lanes[3:0] : lanes[7:4];
        exp_addr = {addr_i[31:2], 2'b00} + ((part_cnt == 0) ? 32'd0 : 32'd4);
        if (data_be_i !== exp_be) report_mismatch("data_be_o", 32'(exp_be), 32'(data_be_i));
        if (data_addr_i !== exp_addr) report_mismatch("data_addr_o", exp_addr, data_addr_i);
        if (data_we_i !== we_i) report_mismatch("data_we_o", 32'(we_i), 32'(data_we_i));
        part_cnt = part_cnt + 1;
      end
      if (data_valid_i) begin
        // first part error or no spill into the next word means one request
        exp_reqs = (err_part_i == 2'd1 || lanes[7:4] == 4'h0) ? 1 : 2;
        if (part_cnt != exp_reqs) report_mismatch("data_req_o grants", exp_reqs, part_cnt);
        if (load_err_i !== (exp_err_i & ~we_i))
          report_mismatch("load_err_o", 32'(exp_err_i & ~we_i), 32'(load_err_i));
        if (store_err_i !== (exp_err_i & we_i))
          report_mismatch("store_err_o", 32'(exp_err_i & we_i), 32'(store_err_i));
        if (!we_i && !exp_err_i && rdata_i !== exp_rdata_i)
          report_mismatch("rdata_o", exp_rdata_i, rdata_i);
        part_cnt = 0;
        done_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/lsu_mem_model.sv ====
//////////////////////////////////////////////////////////////////////
// 64 byte data memory on the request/grant/rvalid bus
// one response pending at a time, addresses wrap at 64 bytes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_wdata_i,
  input  logic        start_i,     // first cycle of a new access
  input  logic [1:0]  err_part_i,  // part that answers with an error
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic        data_err_o,
  output logic [31:0] data_rdata_o
);
  localparam int MEM_BYTES = 64;

  logic [7:0]  mem [MEM_BYTES];
  logic [1:0]  wait_cnt;   // cycles the current request has waited
  logic [1:0]  gnt_delay;
  logic [1:0]  part_cnt;   // grants given in this access
  logic [1:0]  this_part;
  logic        part_err;
  logic [3:0]  word_idx;
  logic        rsp_pend;
  logic [1:0]  rsp_delay;
  logic        rsp_err;
  logic [31:0] rsp_data;

  // fill depends on every address bit
  initial begin
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = 8'(a) ^ 8'h96;
    end
  end

  assign word_idx      = data_addr_i[5:2];
  assign this_part     = start_i ? 2'd1 : part_cnt + 2'd1;
  assign part_err      = (err_part_i != 2'd0) && (err_part_i == this_part);
  assign data_gnt_o    = data_req_i && (wait_cnt >= gnt_delay);
  assign data_rvalid_o = rsp_pend && (rsp_delay == 2'd0);
  assign data_err_o    = data_rvalid_o && rsp_err;
  assign data_rdata_o  = rsp_data;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt  <= 2'd0;
      gnt_delay <= 2'd0;
      part_cnt  <= 2'd0;
      rsp_pend  <= 1'b0;
      rsp_delay <= 2'd0;
      rsp_err   <= 1'b0;
      rsp_data  <= 32'h0;
    end else begin
      if (data_gnt_o) begin
        wait_cnt  <= 2'd0;
        gnt_delay <= 2'($urandom);  // 0 to 3 cycles for the next request
      end else if (data_req_i) begin
        wait_cnt  <= wait_cnt + 2'd1;
      end
      if (start_i) begin
        part_cnt <= data_gnt_o ? 2'd1 : 2'd0;
      end else if (data_gnt_o) begin
        part_cnt <= part_cnt + 2'd1;
      end
      if (data_rvalid_o) begin
        rsp_pend <= 1'b0;
      end else if (rsp_pend) begin
        rsp_delay <= rsp_delay - 2'd1;
      end
      // a grant in the rvalid cycle opens the next response
      if (data_gnt_o) begin
        rsp_pend  <= 1'b1;
        rsp_delay <= 2'($urandom);
        rsp_err   <= part_err;
        rsp_data  <= {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
                      mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};
        if (data_we_i && !part_err) begin  // failed parts leave memory alone
          for (int l = 0; l < 4; l++) begin
            if (data_be_i[l]) mem[{word_idx, 2'(l)}] <= data_wdata_i[8*l +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/lsu_vectors.txt ====
// we size sign_ext addr wdata err_part exp_rdata exp_err
// size 0 word, 1 half, 2 or 3 byte; err_part 0 none, 1 first, 2 second
0 0 0 00000000 00000000 0 95949796 0
0 1 1 00000006 00000000 0 ffff9190 0
0 1 0 00000002 00000000 0 00009594 0
0 2 1 00000005 00000000 0 ffffff93 0
0 3 0 0000000b 00000000 0 0000009d 0
1 0 0 00000010 12345678 0 00000000 0
0 0 0 00000010 00000000 0 12345678 0
1 1 0 0000001a 0000beef 0 00000000 0
0 1 1 0000001a 00000000 0 ffffbeef 0
1 2 0 00000021 0000005a 0 00000000 0
0 2 1 00000021 00000000 0 0000005a 0
0 0 0 00000025 00000000 0 beb1b0b3 0
0 0 0 00000033 00000000 0 a0a3a2a5 0
0 1 1 00000037 00000000 0 ffffaea1 0
1 0 0 0000000d cafef00d 0 00000000 0
0 0 0 0000000c 00000000 0 fef00d9a 0
0 0 0 00000010 00000000 0 123456ca 0
1 1 0 0000003b 00001234 0 00000000 0
0 0 0 00000039 00000000 0 1234acaf 0
0 0 0 00000001 00000000 1 00000000 1
1 0 0 00000006 11223344 1 00000000 1
1 0 0 00000016 aabbccdd 2 00000000 1
0 0 0 00000016 00000000 0 8f8eccdd 0
0 0 0 00000006 00000000 0 9f9e9190 0
0 1 0 00000004 00000000 1 00000000 1
1 2 0 0000002e 000000ff 1 00000000 1
0 2 0 0000002e 00000000 0 000000b8 0
0 1 0 0000001f 00000000 2 00000000 1

// ==== bench/tb_lsu_top.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit testbench driven by accesses from bench/lsu_vectors.txt
// run from the project root with at most 32 vectors of 8 columns
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
  import lsu_op_pkg::*;

  localparam int MAX_VEC        = 32;
  localparam int COLS           = 8;   // columns per vector line
  localparam int CYCLES_PER_VEC = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req, we, sign_ext;
  lsu_size_e   size;
  logic [31:0] addr, wdata;
  logic        data_valid, load_err, store_err;
  logic [31:0] rdata;
  logic        data_req, data_we, data_gnt, data_rvalid, data_err;
  logic [31:0] data_addr, data_wdata, data_rdata;
  logic [3:0]  data_be;
  logic        start, exp_err;
  logic [1:0]  err_part;
  logic [31:0] exp_rdata;
  logic [31:0] vec [MAX_VEC*COLS];
  int unsigned err_cnt, done_cnt;
  int          num_vec;
  int          cur_vec;

  always #4 clk = ~clk;  // 8 ns period

  lsu_top lsu_top_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .we_i (we), .size_i (size), .sign_ext_i (sign_ext),
    .addr_i (addr), .wdata_i (wdata),
    .data_valid_o (data_valid), .rdata_o (rdata),
    .load_err_o (load_err), .store_err_o (store_err),
    .data_req_o (data_req), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_rdata_i (data_rdata)
  );

  lsu_mem_model mem_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
    .data_be_i (data_be), .data_wdata_i (data_wdata),
    .start_i (start), .err_part_i (err_part),
    .data_gnt_o (data_gnt), .data_rvalid_o (data_rvalid),
    .data_err_o (data_err), .data_rdata_o (data_rdata)
  );

  lsu_checker checker_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .we_i (we), .size_i (size), .addr_i (addr),
    .data_req_i (data_req), .data_gnt_i (data_gnt),
    .data_addr_i (data_addr), .data_we_i (data_we), .data_be_i (data_be),
    .data_valid_i (data_valid), .rdata_i (rdata),
    .load_err_i (load_err), .store_err_i (store_err),
    .err_part_i (err_part), .exp_rdata_i (exp_rdata), .exp_err_i (exp_err),
    .err_cnt_o (err_cnt), .done_cnt_o (done_cnt)
  );

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned seed_val;
    int unsigned assert_fails;
    seed_val  = $urandom(39);  // one seed for the whole run
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    size      = LSU_WORD;
    sign_ext  = 1'b0;
    addr      = 32'h0;
    wdata     = 32'h0;
    start     = 1'b0;
    err_part  = 2'd0;
    exp_rdata = 32'h0;
    exp_err   = 1'b0;
    cur_vec   = 0;
    for (int i = 0; i < MAX_VEC*COLS; i++) begin
      vec[i] = 32'hffff_ffff;  // unused lines keep this marker
    end
    $readmemh("bench/lsu_vectors.txt", vec);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec[num_vec*COLS] != 32'hffff_ffff) begin
      num_vec++;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int v = 0; v < num_vec; v++) begin
      @(posedge clk);
      cur_vec   <= v;
      req       <= 1'b1;
      start     <= 1'b1;
      we        <= vec[v*COLS][0];
      size      <= lsu_size_e'(vec[v*COLS+1][1:0]);
      sign_ext  <= vec[v*COLS+2][0];
      addr      <= vec[v*COLS+3];
      wdata     <= vec[v*COLS+4];
      err_part  <= vec[v*COLS+5][1:0];
      exp_rdata <= vec[v*COLS+6];
      exp_err   <= vec[v*COLS+7][0];
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      while (!data_valid) @(negedge clk);  // fields held until completion
    end
    @(posedge clk);
    req <= 1'b0;
    repeat (4) @(posedge clk);
    assert_fails = lsu_top_inst.lsu_bus_sva_inst.fail_cnt;
    if (done_cnt != num_vec) begin
      $display("only %0d of %0d accesses completed", done_cnt, num_vec);
    end
    $display("accesses %0d of %0d, errors %0d, assertion failures %0d",
             done_cnt, num_vec, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0 && done_cnt == num_vec) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // run length scales with the number of vectors
  initial begin : watchdog
    @(posedge rst_n);
    repeat (num_vec * CYCLES_PER_VEC) @(posedge clk);
    $display("timeout: access %0d of %0d got no data_valid_o", cur_vec + 1, num_vec);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/lsu_bus_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_req_decode.sv
hdl/lsu_bus_fsm.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_checker.sv
bench/lsu_bus_sva.sv
bench/tb_lsu_top.sv

// ==== hdl/lsu_bus_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// bus sequencer for one access at a time, split into at most two parts
// core fields must stay stable from req_i until data_valid_o
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_bus_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  lsu_op_pkg::lsu_size_e             size_i,
  input  logic                              sign_ext_i,
  input  logic [lsu_bus_pkg::OFFS_W-1:0]    offset_i,
  input  logic                              split_i,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  input  logic                              data_err_i,
  output logic                              data_req_o,
  output logic                              second_part_o,
  output logic                              first_rdata_en_o,  // hold first read word
  output lsu_op_pkg::lsu_size_e             size_q_o,
  output logic                              sign_ext_q_o,
  output logic [lsu_bus_pkg::OFFS_W-1:0]    offset_q_o,
  output logic                              data_valid_o,
  output logic                              load_err_o,
  output logic                              store_err_o
);
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;

  lsu_state_e        state_q, state_d;
  logic              misaligned_q, misaligned_d;  // first part of a split access granted
  logic              ctx_update;
  logic              err_pulse;
  logic              we_q;
  lsu_size_e         size_q;
  logic              sign_ext_q;
  logic [OFFS_W-1:0] offset_q;

  ////////////////////////////////////////////////////////////////////
  // next state and bus request
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    misaligned_d     = misaligned_q;
    data_req_o       = 1'b0;
    data_valid_o     = 1'b0;
    first_rdata_en_o = 1'b0;
    err_pulse        = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;  // request goes out in the same cycle
          if (data_gnt_i) begin
            misaligned_d = split_i;
            state_d      = split_i ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            state_d      = split_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          misaligned_d = 1'b1;
          state_d      = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        if (data_rvalid_i) begin
          if (data_err_i) begin     // first part failed, drop the second one
            data_valid_o = 1'b1;
            err_pulse    = 1'b1;
            misaligned_d = 1'b0;
            state_d      = IDLE;
          end else begin
            first_rdata_en_o = ~we_q;  // keep the low bytes of a split load
            data_req_o       = 1'b1;   // second part leaves with the first rvalid
            state_d          = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o = 1'b1;      // completes with the last response
          err_pulse    = data_err_i;
          misaligned_d = 1'b0;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // state and access context
  ////////////////////////////////////////////////////////////////////

  assign ctx_update = data_req_o & data_gnt_i;  // accepted request

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      misaligned_q <= 1'b0;
      we_q         <= 1'b0;
      size_q       <= LSU_WORD;
      sign_ext_q   <= 1'b0;
      offset_q     <= '0;
    end else begin
      state_q      <= state_d;
      misaligned_q <= misaligned_d;
      if (ctx_update) begin
        we_q       <= we_i;
        size_q     <= size_i;
        sign_ext_q <= sign_ext_i;
        offset_q   <= offset_i;
      end
    end
  end

  assign second_part_o = misaligned_q;
  assign size_q_o      = size_q;
  assign sign_ext_q_o  = sign_ext_q;
  assign offset_q_o    = offset_q;

  // error type follows the access that was granted
  assign load_err_o    = err_pulse & ~we_q;
  assign store_err_o   = err_pulse &  we_q;

endmodule

`default_nettype wire

// ==== hdl/lsu_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// data bus geometry for the load/store unit
// bus and address are fixed at 32 bits with four byte lanes
//////////////////////////////////////////////////////////////////////

`default_nettype none

package lsu_bus_pkg;

  ////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned BUS_W  = 32;  // read and write data width
  localparam int unsigned BE_W   = 4;   // one enable per byte lane
  localparam int unsigned ADDR_W = 32;  // byte address width

  ////////////////////////////////////////////////////////////////////
  // address constants
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned OFFS_W     = 2;  // byte offset inside a word
  localparam int unsigned WORD_BYTES = 4;  // step from first to second part

endpackage

`default_nettype wire

// ==== hdl/lsu_op_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// access and sequencing types of the load/store unit
// size code 2'b11 has no name of its own and decodes as a byte
//////////////////////////////////////////////////////////////////////

`default_nettype none

package lsu_op_pkg;

  ////////////////////////////////////////////////////////////////////
  // access size as driven by the execute stage
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,  // 32 bit access
    LSU_HALF = 2'b01,  // 16 bit access
    LSU_BYTE = 2'b10   // 8 bit access, 2'b11 is treated the same
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////
  // bus sequencer states
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,             // no access pending
    WAIT_GNT_MIS,     // first part of a split access waits for grant
    WAIT_RVALID_MIS,  // first part granted, waiting for its response
    WAIT_GNT,         // single or second part waits for grant
    WAIT_RVALID       // last part granted, waiting for its response
  } lsu_state_e;

  // a half word at this offset reaches into the next word
  localparam logic [1:0] OFFS_HALF_SPLIT = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/lsu_rdata_align.sv ====
//////////////////////////////////////////////////////////////////////
// read data merge and extension
// result is valid only in the cycle of the final rvalid
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [lsu_bus_pkg::BUS_W-1:0]     data_rdata_i,
  input  logic                              first_rdata_en_i,
  input  lsu_op_pkg::lsu_size_e             size_i,      // registered at grant
  input  logic                              sign_ext_i,
  input  logic [lsu_bus_pkg::OFFS_W-1:0]    offset_i,
  output logic [lsu_bus_pkg::BUS_W-1:0]     rdata_o
);
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;

  logic [BUS_W-1:0] rdata_q;  // first word of a split load
  logic [BUS_W-1:0] rdata_w;
  logic [BUS_W-1:0] rdata_h;
  logic [BUS_W-1:0] rdata_b;
  logic [15:0]      half;
  logic [7:0]       byte_val;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (first_rdata_en_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // lane selection
  ////////////////////////////////////////////////////////////////////

  // low bytes come from the held word, high bytes from the current one
  always_comb begin
    unique case (offset_i)
      2'd0:    rdata_w = data_rdata_i;
      2'd1:    rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (offset_i)
      2'd0:    half = data_rdata_i[15:0];
      2'd1:    half = data_rdata_i[23:8];
      2'd2:    half = data_rdata_i[31:16];
      default: half = {data_rdata_i[7:0], rdata_q[31:24]};  // crosses the word
    endcase
  end

  assign byte_val = data_rdata_i[{offset_i, 3'b000} +: 8];

  // zero or sign extension
  assign rdata_h = {{16{sign_ext_i & half[15]}}, half};
  assign rdata_b = {{24{sign_ext_i & byte_val[7]}}, byte_val};

  always_comb begin
    unique case (size_i)
      LSU_WORD: rdata_o = rdata_w;
      LSU_HALF: rdata_o = rdata_h;
      default:  rdata_o = rdata_b;  // both byte codes
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_req_decode.sv ====
//////////////////////////////////////////////////////////////////////
// purely combinational request decode
// addr_i must stay stable for both parts of a split access
// the second part address is formed here as the first word plus 4
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode (
  input  lsu_op_pkg::lsu_size_e             size_i,
  input  logic [lsu_bus_pkg::ADDR_W-1:0]    addr_i,
  input  logic [lsu_bus_pkg::BUS_W-1:0]     wdata_i,
  input  logic                              second_part_i,  // first part already granted
  output logic                              split_o,
  output logic [lsu_bus_pkg::ADDR_W-1:0]    bus_addr_o,
  output logic [lsu_bus_pkg::BE_W-1:0]      be_o,
  output logic [lsu_bus_pkg::BUS_W-1:0]     bus_wdata_o
);
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;

  logic [OFFS_W-1:0] offset;
  logic [ADDR_W-1:0] word_addr;

  assign offset    = addr_i[OFFS_W-1:0];
  assign word_addr = {addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};

  ////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (size_i)
      LSU_WORD: begin
        if (!second_part_i) begin     // upper lanes of the first word
          unique case (offset)
            2'd0:    be_o = 4'b1111;
            2'd1:    be_o = 4'b1110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin                // remaining lanes in the next word
          unique case (offset)
            2'd0:    be_o = 4'b0000;  // never issued, aligned words do not split
            2'd1:    be_o = 4'b0001;
            2'd2:    be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end
      end
      LSU_HALF: begin
        if (!second_part_i) begin
          unique case (offset)
            2'd0:    be_o = 4'b0011;
            2'd1:    be_o = 4'b0110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin
          be_o = 4'b0001;             // only the upper byte spills over
        end
      end
      default: be_o = 4'b0001 << offset;  // byte, both size codes
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // write data lane rotation
  ////////////////////////////////////////////////////////////////////

  // rotate left by the offset so each byte meets its lane in either part
  always_comb begin
    unique case (offset)
      2'd0:    bus_wdata_o = wdata_i;
      2'd1:    bus_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    bus_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: bus_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // unaligned word, or half word crossing into the next word
  assign split_o = ((size_i == LSU_WORD) && (offset != '0)) ||
                   ((size_i == LSU_HALF) && (offset == OFFS_HALF_SPLIT));

  assign bus_addr_o = second_part_i ? word_addr + ADDR_W'(WORD_BYTES)  // next word
                                    : word_addr;

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit top, request/grant/rvalid data bus
// one access in flight, core holds its fields until data_valid_o
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // core side
  input  logic                              req_i,
  input  logic                              we_i,
  input  lsu_op_pkg::lsu_size_e             size_i,
  input  logic                              sign_ext_i,
  input  logic [lsu_bus_pkg::ADDR_W-1:0]    addr_i,
  input  logic [lsu_bus_pkg::BUS_W-1:0]     wdata_i,
  output logic                              data_valid_o,
  output logic [lsu_bus_pkg::BUS_W-1:0]     rdata_o,
  output logic                              load_err_o,
  output logic                              store_err_o,
  // data bus
  output logic                              data_req_o,
  output logic [lsu_bus_pkg::ADDR_W-1:0]    data_addr_o,  // word aligned
  output logic                              data_we_o,
  output logic [lsu_bus_pkg::BE_W-1:0]      data_be_o,
  output logic [lsu_bus_pkg::BUS_W-1:0]     data_wdata_o,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  input  logic                              data_err_i,
  input  logic [lsu_bus_pkg::BUS_W-1:0]     data_rdata_i
);
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;

  logic              split;
  logic              second_part;
  logic              first_rdata_en;
  lsu_size_e         size_q;
  logic              sign_ext_q;
  logic [OFFS_W-1:0] offset_q;

  lsu_req_decode lsu_req_decode_inst (
    .size_i        (size_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .second_part_i (second_part),
    .split_o       (split),
    .bus_addr_o    (data_addr_o),
    .be_o          (data_be_o),
    .bus_wdata_o   (data_wdata_o)
  );

  lsu_bus_fsm lsu_bus_fsm_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .we_i             (we_i),
    .size_i           (size_i),
    .sign_ext_i       (sign_ext_i),
    .offset_i         (addr_i[OFFS_W-1:0]),
    .split_i          (split),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_err_i       (data_err_i),
    .data_req_o       (data_req_o),
    .second_part_o    (second_part),
    .first_rdata_en_o (first_rdata_en),
    .size_q_o         (size_q),
    .sign_ext_q_o     (sign_ext_q),
    .offset_q_o       (offset_q),
    .data_valid_o     (data_valid_o),
    .load_err_o       (load_err_o),
    .store_err_o      (store_err_o)
  );

  lsu_rdata_align lsu_rdata_align_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_rdata_i     (data_rdata_i),
    .first_rdata_en_i (first_rdata_en),
    .size_i           (size_q),
    .sign_ext_i       (sign_ext_q),
    .offset_i         (offset_q),
    .rdata_o          (rdata_o)
  );

  assign data_we_o = we_i;  // write enable goes straight to the bus

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the load/store unit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lsu_top \
  --Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vtb_lsu_top)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
